//--- vlog.f
design/lc3b_types.sv
design/cache_array.sv
design/line_update.sv
design/cache_datapath.sv
design/cache_control.sv
design/cache.sv
tb/cache_assertions.sv
tb/cache_tb.sv

//--- tb/cache_tb.sv
`default_nettype none

module cache_tb;

	localparam int ack_timeout = 200;
	localparam int num_accesses = 25;

	typedef struct packed {
		logic write;
		lc3b_types::lc3b_word addr;
		lc3b_types::lc3b_wmask byte_enable;
		logic [1:0] transfers;
	} access_t;

	logic clk;
	logic reset;
	logic mem_req;
	lc3b_types::mem_req_t mem_cmd;
	logic mem_ack;
	lc3b_types::lc3b_word mem_rdata;
	logic pmem_req;
	lc3b_types::pmem_req_t pmem_cmd;
	logic pmem_ack;
	lc3b_types::lc3b_c_block pmem_rdata;

	lc3b_types::lc3b_word mem_words [32768];
	logic [7:0] shadow [65536];
	lc3b_types::lc3b_c_block fill_line;
	logic mem_busy;
	int mem_delay;
	logic pmem_req_q;
	int total_xfers;
	int access_base;
	int error_count;
	int timeout_count;

	// expected tags and lru per set, gives the writeback address of a miss
	lc3b_types::lc3b_c_tag model_tag [lc3b_types::default_num_sets][2];
	logic model_valid [lc3b_types::default_num_sets][2];
	lc3b_types::way_sel_t model_lru [lc3b_types::default_num_sets];
	lc3b_types::lc3b_word wb_addr;

	// set 2 cycles tags 0, 1, 2 for lru and dirty eviction, set 5 covers a write miss
	access_t access_table [num_accesses] = '{
		'{1'b0, 16'h0020, 2'b00, 2'd1}, '{1'b0, 16'h0022, 2'b00, 2'd0},
		'{1'b0, 16'h002e, 2'b00, 2'd0}, '{1'b1, 16'h0024, 2'b01, 2'd0},
		'{1'b1, 16'h0026, 2'b10, 2'd0}, '{1'b1, 16'h0028, 2'b11, 2'd0},
		'{1'b0, 16'h0024, 2'b00, 2'd0}, '{1'b0, 16'h0026, 2'b00, 2'd0},
		'{1'b0, 16'h0028, 2'b00, 2'd0}, '{1'b0, 16'h00a0, 2'b00, 2'd1},
		'{1'b0, 16'h0022, 2'b00, 2'd0}, '{1'b0, 16'h0120, 2'b00, 2'd1},
		'{1'b0, 16'h0020, 2'b00, 2'd0}, '{1'b0, 16'h00a0, 2'b00, 2'd1},
		'{1'b0, 16'h0120, 2'b00, 2'd2}, '{1'b0, 16'h0024, 2'b00, 2'd1},
		'{1'b0, 16'h0026, 2'b00, 2'd0}, '{1'b0, 16'h0028, 2'b00, 2'd0},
		'{1'b1, 16'h0352, 2'b11, 2'd1}, '{1'b0, 16'h0352, 2'b00, 2'd0},
		'{1'b0, 16'hfffe, 2'b00, 2'd1}, '{1'b0, 16'hfff0, 2'b00, 2'd0},
		'{1'b0, 16'h0452, 2'b00, 2'd1}, '{1'b0, 16'h0552, 2'b00, 2'd2},
		'{1'b0, 16'h0352, 2'b00, 2'd1}
	};

	cache #(.num_sets(lc3b_types::default_num_sets)) UUT
	(
		.clk, .reset, .mem_req, .mem_cmd, .mem_ack, .mem_rdata,
		.pmem_req, .pmem_cmd, .pmem_ack, .pmem_rdata
	);

	always #2 clk = ~clk;

	task automatic check_value(input string name, input logic [127:0] actual,
		input logic [127:0] expected);
		if (actual !== expected)
		begin
			$display("mismatch %s: actual %0h expected %0h", name, actual, expected);
			error_count++;
		end
	endtask

	function automatic lc3b_types::lc3b_word shadow_word(input lc3b_types::lc3b_word addr);
		return {shadow[{addr[15:1], 1'b1}], shadow[{addr[15:1], 1'b0}]};
	endfunction

	function automatic lc3b_types::lc3b_c_block shadow_line(input lc3b_types::lc3b_word addr);
		lc3b_types::lc3b_c_block line;
		for (int b = 0; b < 16; b++)
			line[b * 8 +: 8] = shadow[{addr[15:4], 4'b0000} + b];
		return line;
	endfunction

	task automatic track_tags(input lc3b_types::lc3b_word addr);
		lc3b_types::lc3b_c_index index;
		lc3b_types::lc3b_c_tag tag;
		lc3b_types::way_sel_t way;
		index = addr[6:4];
		tag = addr[15:7];
		if (model_valid[index][0] && model_tag[index][0] == tag)
			way = 1'b0;
		else if (model_valid[index][1] && model_tag[index][1] == tag)
			way = 1'b1;
		else
		begin
			// miss replaces the way not used last
			way = model_lru[index];
			wb_addr = {model_tag[index][way], index, 4'h0};
			model_tag[index][way] = tag;
			model_valid[index][way] = 1'b1;
		end
		model_lru[index] = ~way;
	endtask

	// behavioral memory, answers each transfer after a random delay
	always @(posedge clk)
	begin
		if (reset)
		begin
			pmem_ack <= 1'b0;
			mem_busy <= 1'b0;
			mem_delay <= 0;
		end
		else if (pmem_ack)
		begin
			if (!pmem_req)
				pmem_ack <= 1'b0;
		end
		else if (mem_busy)
		begin
			if (mem_delay > 0)
				mem_delay <= mem_delay - 1;
			else
			begin
				if (pmem_cmd.write)
				begin
					check_value("pmem_wdata", pmem_cmd.wdata, shadow_line(wb_addr));
					for (int w = 0; w < 8; w++)
						mem_words[pmem_cmd.addr[15:1] + w] = pmem_cmd.wdata[w * 16 +: 16];
				end
				else
				begin
					for (int w = 0; w < 8; w++)
						fill_line[w * 16 +: 16] = mem_words[pmem_cmd.addr[15:1] + w];
					pmem_rdata <= fill_line;
				end
				pmem_ack <= 1'b1;
				mem_busy <= 1'b0;
			end
		end
		else if (pmem_req)
		begin
			if (pmem_cmd.write)
			begin
				check_value("pmem_addr", pmem_cmd.addr, wb_addr);
				// writeback must precede the fill of the same access
				check_value("writeback_order", total_xfers - access_base, 0);
			end
			else
				check_value("pmem_addr", pmem_cmd.addr, {mem_cmd.addr.raw[15:4], 4'h0});
			mem_busy <= 1'b1;
			mem_delay <= $urandom_range(0, 3);
		end
	end

	// counts memory transfers
	always @(posedge clk)
	begin
		if (reset)
		begin
			pmem_req_q <= 1'b0;
			total_xfers <= 0;
		end
		else
		begin
			pmem_req_q <= pmem_req;
			if (pmem_req && !pmem_req_q)
				total_xfers <= total_xfers + 1;
		end
	end

	task automatic run_access(input access_t entry);
		lc3b_types::mem_req_t cmd;
		int cycles;
		int hold;
		cmd.addr.raw = entry.addr;
		cmd.wdata = $urandom;
		cmd.byte_enable = entry.byte_enable;
		cmd.write = entry.write;
		track_tags(entry.addr);
		access_base = total_xfers;
		mem_cmd <= cmd;
		mem_req <= 1'b1;
		cycles = 0;
		do
		begin
			@(posedge clk);
			cycles++;
		end while (!mem_ack && cycles < ack_timeout);
		if (!mem_ack)
		begin
			$display("timeout: no mem_ack for access to address %h", entry.addr);
			timeout_count++;
			return;
		end
		if (!entry.write)
			check_value("mem_rdata", mem_rdata, shadow_word(entry.addr));
		check_value("pmem_transfers", total_xfers - access_base, entry.transfers);
		// cpu holds the request a little to test back-pressure
		hold = $urandom_range(0, 2);
		repeat (hold)
		begin
			@(posedge clk);
			check_value("mem_ack", mem_ack, 1'b1);
		end
		mem_req <= 1'b0;
		cycles = 0;
		do
		begin
			@(posedge clk);
			cycles++;
		end while (mem_ack && cycles < ack_timeout);
		if (mem_ack)
		begin
			$display("timeout: mem_ack stayed high after address %h", entry.addr);
			timeout_count++;
			return;
		end
		for (int b = 0; b < 2; b++)
		begin
			if (entry.write && entry.byte_enable[b])
				shadow[{entry.addr[15:1], 1'b0} + b] = cmd.wdata[b * 8 +: 8];
		end
	endtask

	initial
	begin
		void'($urandom(32'h6d56));
		clk = 1'b0;
		reset <= 1'b1;
		mem_req <= 1'b0;
		mem_cmd <= '0;
		pmem_ack <= 1'b0;
		pmem_rdata <= '0;
		error_count = 0;
		timeout_count = 0;
		access_base = 0;
		wb_addr = '0;
		for (int s = 0; s < lc3b_types::default_num_sets; s++)
		begin
			model_lru[s] = 1'b0;
			for (int w = 0; w < 2; w++)
			begin
				model_tag[s][w] = '0;
				model_valid[s][w] = 1'b0;
			end
		end
		// each word holds its byte address xor 16'h6d56
		for (int a = 0; a < 65536; a += 2)
		begin
			mem_words[a / 2] = a[15:0] ^ 16'h6d56;
			shadow[a] = mem_words[a / 2][7:0];
			shadow[a + 1] = mem_words[a / 2][15:8];
		end
		repeat (8) @(posedge clk);
		reset <= 1'b0;
		@(posedge clk);
		check_value("mem_ack", mem_ack, 1'b0);
		check_value("pmem_req", pmem_req, 1'b0);
		for (int i = 0; i < num_accesses && timeout_count == 0; i++)
			run_access(access_table[i]);
		$display("errors: %0d mismatches, %0d timeouts, %0d assertion failures",
			error_count, timeout_count, UUT.assertions.failure_count);
		if (error_count == 0 && timeout_count == 0 && UUT.assertions.failure_count == 0)
			$display("Result: PASSED");
		else
			$display("Result: FAILED");
		$finish;
	end

endmodule : cache_tb

`default_nettype wire

//--- tb/cache_assertions.sv
`default_nettype none

module cache_assertions
(
	input wire logic clk,
	input wire logic reset,
	input wire logic mem_req,
	input wire lc3b_types::mem_req_t mem_cmd,
	input wire logic mem_ack,
	input wire logic pmem_req,
	input wire lc3b_types::pmem_req_t pmem_cmd,
	input wire logic pmem_ack
);

	int failure_count = 0;

	// an ack only answers a pending request
	mem_ack_after_req: assert property (@(posedge clk) disable iff (reset)
		$rose(mem_ack) |-> mem_req)
		else begin failure_count++; $error("mem_ack rose without mem_req"); end

	pmem_ack_after_req: assert property (@(posedge clk) disable iff (reset)
		$rose(pmem_ack) |-> pmem_req)
		else begin failure_count++; $error("pmem_ack rose without pmem_req"); end

	// new request only once the last ack is gone
	mem_req_after_release: assert property (@(posedge clk) disable iff (reset)
		$rose(mem_req) |-> !mem_ack)
		else begin failure_count++; $error("mem_req rose while mem_ack high"); end

	mem_cmd_stable: assert property (@(posedge clk) disable iff (reset)
		(mem_req && $past(mem_req)) |-> $stable(mem_cmd))
		else begin failure_count++; $error("mem_cmd changed while mem_req high"); end

	pmem_cmd_stable: assert property (@(posedge clk) disable iff (reset)
		(pmem_req && $past(pmem_req)) |-> $stable(pmem_cmd))
		else begin failure_count++; $error("pmem_cmd changed while pmem_req high"); end

endmodule : cache_assertions

bind cache cache_assertions assertions
(
	.clk, .reset, .mem_req, .mem_cmd, .mem_ack,
	.pmem_req, .pmem_cmd, .pmem_ack
);

`default_nettype wire

//--- design/cache.sv
`default_nettype none

module cache
#(
	parameter int num_sets = lc3b_types::default_num_sets
)
(
	input wire logic clk,
	input wire logic reset,

	input wire logic mem_req,
	input wire lc3b_types::mem_req_t mem_cmd,
	output logic mem_ack,
	output lc3b_types::lc3b_word mem_rdata,

	output logic pmem_req,
	output lc3b_types::pmem_req_t pmem_cmd,
	input wire logic pmem_ack,
	input wire lc3b_types::lc3b_c_block pmem_rdata
);

	logic [1:0] ld_way;
	logic [1:0] ld_valid;
	logic [1:0] ld_tag;
	logic [1:0] ld_dirty;
	logic ld_lru;
	logic dirty_in;
	logic fill_sel;
	lc3b_types::way_sel_t way_sel;
	logic [1:0] addr_sel;

	logic hit;
	lc3b_types::way_sel_t hit_way;
	lc3b_types::way_sel_t lru;
	logic victim_dirty;
	logic pmem_write;
	lc3b_types::lc3b_word pmem_addr;
	lc3b_types::lc3b_c_block pmem_wdata;

	assign pmem_cmd = '{addr: pmem_addr, wdata: pmem_wdata, write: pmem_write};

	cache_datapath #(.num_sets(num_sets)) datapath
	(
		.clk, .reset, .mem_cmd, .pmem_rdata,
		.ld_way, .ld_valid, .ld_tag, .ld_dirty, .ld_lru,
		.dirty_in, .fill_sel, .way_sel, .addr_sel,
		.hit, .hit_way, .lru, .victim_dirty,
		.mem_rdata, .pmem_addr, .pmem_wdata
	);

	cache_control control
	(
		.clk, .reset, .mem_req, .mem_write(mem_cmd.write),
		.hit, .hit_way, .lru, .victim_dirty, .pmem_ack,
		.mem_ack, .pmem_req, .pmem_write,
		.ld_way, .ld_valid, .ld_tag, .ld_dirty, .ld_lru,
		.dirty_in, .fill_sel, .way_sel, .addr_sel
	);

endmodule : cache

`default_nettype wire

//--- design/cache_control.sv
`default_nettype none

module cache_control
(
	input wire logic clk,
	input wire logic reset,
	input wire logic mem_req,
	input wire logic mem_write,
	input wire logic hit,
	input wire lc3b_types::way_sel_t hit_way,
	input wire lc3b_types::way_sel_t lru,
	input wire logic victim_dirty,
	input wire logic pmem_ack,

	output logic mem_ack,
	output logic pmem_req,
	output logic pmem_write,

	output logic [1:0] ld_way,
	output logic [1:0] ld_valid,
	output logic [1:0] ld_tag,
	output logic [1:0] ld_dirty,
	output logic ld_lru,
	output logic dirty_in,
	output logic fill_sel,
	output lc3b_types::way_sel_t way_sel,
	output logic [1:0] addr_sel
);

	typedef enum logic [2:0] {
		s_idle,
		s_respond,
		s_wb_req,
		s_wb_rel,
		s_fill_req,
		s_fill_rel
	} state_t;

	state_t state;
	state_t next_state;
	logic [1:0] hit_mask;
	logic [1:0] victim_mask;
	logic [1:0] victim_addr_sel;

	assign hit_mask = hit_way ? 2'b10 : 2'b01;
	assign victim_mask = lru ? 2'b10 : 2'b01;
	assign victim_addr_sel = lru ? lc3b_types::addr_sel_way1 : lc3b_types::addr_sel_way0;

	always_ff @(posedge clk)
	begin
		if (reset)
			state <= s_idle;
		else
			state <= next_state;
	end

	always_comb
	begin
		next_state = state;
		mem_ack = 1'b0;
		pmem_req = 1'b0;
		pmem_write = 1'b0;
		ld_way = 2'b00;
		ld_valid = 2'b00;
		ld_tag = 2'b00;
		ld_dirty = 2'b00;
		ld_lru = 1'b0;
		dirty_in = 1'b0;
		fill_sel = 1'b0;
		way_sel = lru;
		addr_sel = lc3b_types::addr_sel_cpu;

		case (state)
			s_idle:
			begin
				if (mem_req && hit)
				begin
					way_sel = hit_way;
					ld_lru = 1'b1;
					if (mem_write)
					begin
						// merged line goes back into the hit way
						ld_way = hit_mask;
						ld_dirty = hit_mask;
						dirty_in = 1'b1;
					end
					next_state = s_respond;
				end
				else if (mem_req)
					next_state = victim_dirty ? s_wb_req : s_fill_req;
			end

			s_respond:
			begin
				way_sel = hit_way;
				mem_ack = 1'b1;
				if (!mem_req)
					next_state = s_idle;
			end

			s_wb_req:
			begin
				pmem_req = 1'b1;
				pmem_write = 1'b1;
				addr_sel = victim_addr_sel;
				if (pmem_ack)
					next_state = s_wb_rel;
			end

			s_wb_rel:
			begin
				pmem_write = 1'b1;
				addr_sel = victim_addr_sel;
				if (!pmem_ack)
					next_state = s_fill_req;
			end

			s_fill_req:
			begin
				pmem_req = 1'b1;
				if (pmem_ack)
				begin
					// new line arrives clean
					fill_sel = 1'b1;
					ld_way = victim_mask;
					ld_tag = victim_mask;
					ld_valid = victim_mask;
					ld_dirty = victim_mask;
					next_state = s_fill_rel;
				end
			end

			s_fill_rel:
			begin
				// back to compare, access then completes as a hit
				if (!pmem_ack)
					next_state = s_idle;
			end

			default:
				next_state = s_idle;
		endcase
	end

endmodule : cache_control

`default_nettype wire

//--- design/cache_datapath.sv
`default_nettype none

module cache_datapath
#(
	parameter int num_sets = lc3b_types::default_num_sets
)
(
	input wire logic clk,
	input wire logic reset,
	input wire lc3b_types::mem_req_t mem_cmd,
	input wire lc3b_types::lc3b_c_block pmem_rdata,

	input wire logic [1:0] ld_way,
	input wire logic [1:0] ld_valid,
	input wire logic [1:0] ld_tag,
	input wire logic [1:0] ld_dirty,
	input wire logic ld_lru,
	input wire logic dirty_in,
	input wire logic fill_sel,
	input wire lc3b_types::way_sel_t way_sel,
	input wire logic [1:0] addr_sel,

	output logic hit,
	output lc3b_types::way_sel_t hit_way,
	output lc3b_types::way_sel_t lru,
	output logic victim_dirty,
	output lc3b_types::lc3b_word mem_rdata,
	output lc3b_types::lc3b_word pmem_addr,
	output lc3b_types::lc3b_c_block pmem_wdata
);

	lc3b_types::lc3b_c_tag req_tag;
	lc3b_types::lc3b_c_index req_index;
	lc3b_types::lc3b_c_offset req_offset;

	lc3b_types::lc3b_c_block way_line [lc3b_types::num_ways];
	lc3b_types::lc3b_c_tag way_tag [lc3b_types::num_ways];
	logic way_valid [lc3b_types::num_ways];
	logic way_dirty [lc3b_types::num_ways];
	logic way_hit [lc3b_types::num_ways];

	lc3b_types::lc3b_c_block line_sel;
	lc3b_types::lc3b_c_block merged_line;
	lc3b_types::lc3b_c_block line_in;

	assign req_tag = mem_cmd.addr.fields.tag;
	assign req_index = mem_cmd.addr.fields.index;
	assign req_offset = mem_cmd.addr.fields.offset;

	// fill line from memory or cpu word merged into current line
	assign line_in = fill_sel ? pmem_rdata : merged_line;

	for (genvar w = 0; w < lc3b_types::num_ways; w++)
	begin : g_way
		cache_array #(.width($bits(lc3b_types::lc3b_c_block)), .depth(num_sets)) data_array
		(
			.clk, .reset, .write(ld_way[w]), .index(req_index),
			.datain(line_in), .dataout(way_line[w])
		);

		cache_array #(.width($bits(lc3b_types::lc3b_c_tag)), .depth(num_sets)) tag_array
		(
			.clk, .reset, .write(ld_tag[w]), .index(req_index),
			.datain(req_tag), .dataout(way_tag[w])
		);

		cache_array #(.width(1), .depth(num_sets)) valid_array
		(
			.clk, .reset, .write(ld_valid[w]), .index(req_index),
			.datain(1'b1), .dataout(way_valid[w])
		);

		cache_array #(.width(1), .depth(num_sets)) dirty_array
		(
			.clk, .reset, .write(ld_dirty[w]), .index(req_index),
			.datain(dirty_in), .dataout(way_dirty[w])
		);

		assign way_hit[w] = way_valid[w] && (way_tag[w] == req_tag);
	end

	// lru holds the way not used last, i.e. the next victim
	cache_array #(.width(1), .depth(num_sets)) lru_array
	(
		.clk, .reset, .write(ld_lru), .index(req_index),
		.datain(~way_sel), .dataout(lru)
	);

	assign hit = way_hit[0] | way_hit[1];
	assign hit_way = way_hit[1];
	assign victim_dirty = way_dirty[lru];

	assign line_sel = way_line[way_sel];
	assign mem_rdata = line_sel[req_offset[3:1] * 16 +: 16];
	assign pmem_wdata = line_sel;

	line_update update
	(
		.line_in(line_sel),
		.offset(req_offset),
		.byte_enable(mem_cmd.byte_enable),
		.wdata(mem_cmd.wdata),
		.line_out(merged_line)
	);

	always_comb
	begin
		case (addr_sel)
			lc3b_types::addr_sel_way0:
				pmem_addr = {way_tag[0], req_index, 4'b0000};
			lc3b_types::addr_sel_way1:
				pmem_addr = {way_tag[1], req_index, 4'b0000};
			default:
				pmem_addr = {req_tag, req_index, 4'b0000};
		endcase
	end

endmodule : cache_datapath

`default_nettype wire

//--- design/line_update.sv
`default_nettype none

module line_update
(
	input wire lc3b_types::lc3b_c_block line_in,
	input wire lc3b_types::lc3b_c_offset offset,
	input wire lc3b_types::lc3b_wmask byte_enable,
	input wire lc3b_types::lc3b_word wdata,
	output lc3b_types::lc3b_c_block line_out
);

	logic [2:0] word_index;

	// offset[0] ignored, words are aligned
	assign word_index = offset[3:1];

	always_comb
	begin
		line_out = line_in;
		for (int b = 0; b < $bits(lc3b_types::lc3b_wmask); b++)
		begin
			if (byte_enable[b])
				line_out[word_index * 16 + b * 8 +: 8] = wdata[b * 8 +: 8];
		end
	end

endmodule : line_update

`default_nettype wire

//--- design/cache_array.sv
`default_nettype none

module cache_array
#(
	parameter int width = 1,
	parameter int depth = 8
)
(
	input wire logic clk,
	input wire logic reset,
	input wire logic write,
	input wire lc3b_types::lc3b_c_index index,
	input wire logic [width-1:0] datain,
	output logic [width-1:0] dataout
);

	logic [width-1:0] data [depth];

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			for (int i = 0; i < depth; i++)
				data[i] <= '0;
		end
		else if (write)
			data[index] <= datain;
	end

	// read is not registered
	assign dataout = data[index];

endmodule : cache_array

`default_nettype wire

//--- design/lc3b_types.sv
`default_nettype none

package lc3b_types;

	typedef logic [15:0] lc3b_word;
	typedef logic [8:0] lc3b_c_tag;
	typedef logic [2:0] lc3b_c_index;
	typedef logic [3:0] lc3b_c_offset;
	typedef logic [127:0] lc3b_c_block;
	// bit 0 enables the low byte
	typedef logic [1:0] lc3b_wmask;

	// names way 0 or way 1
	typedef logic way_sel_t;

	typedef struct packed {
		lc3b_c_tag tag;
		lc3b_c_index index;
		lc3b_c_offset offset;
	} cache_addr_fields_t;

	typedef union packed {
		lc3b_word raw;
		cache_addr_fields_t fields;
	} cache_addr_t;

	typedef struct packed {
		cache_addr_t addr;
		lc3b_word wdata;
		lc3b_wmask byte_enable;
		logic write;
	} mem_req_t;

	// addr is always line aligned
	typedef struct packed {
		lc3b_word addr;
		lc3b_c_block wdata;
		logic write;
	} pmem_req_t;

	localparam int num_ways = 2;
	localparam int default_num_sets = 8;

	// memory address source
	localparam logic [1:0] addr_sel_cpu = 2'd0;
	localparam logic [1:0] addr_sel_way0 = 2'd1;
	localparam logic [1:0] addr_sel_way1 = 2'd2;

endpackage : lc3b_types

`default_nettype wire
